// File: include/ex_consts.svh
// Width and size constants for the fixed-latency execute stage
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath and address width
`define EX_XLEN 32

// Scoreboard transaction ID width
`define EX_TRANS_ID_BITS 3

// CSR address and ASID widths
`define EX_CSR_ADDR_BITS 12
`define EX_ASID_BITS 9

// Operator encoding width
`define EX_OP_BITS 5

// Instruction sizes in bytes, compressed and normal
`define EX_INSTR_BYTES_C 2
`define EX_INSTR_BYTES 4

`endif

// File: list.f
+incdir+include
rtl/ex_pkg.sv
rtl/fu_data_if.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/csr_buffer.sv
rtl/multiplier.sv
rtl/sfence_capture.sv
rtl/ex_stage.sv
testbench/tb_ex_stage.sv

// File: rtl/alu.sv
// Combinational ALU with arithmetic, logic, shift, set-less-than and branch compares
`include "ex_consts.svh"

module alu (
    fu_data_if.unit        fu_i,
    input  logic           valid_i,
    output ex_pkg::xlen_t  result_o,
    output logic           branch_taken_o
);

    localparam int unsigned SHAMT_BITS = $clog2(`EX_XLEN);

    logic [SHAMT_BITS-1:0] shamt;
    logic                  less_signed;
    logic                  less_unsigned;
    logic                  equal;

    assign shamt         = fu_i.operand_b[SHAMT_BITS-1:0];
    assign less_signed   = $signed(fu_i.operand_a) < $signed(fu_i.operand_b);
    assign less_unsigned = fu_i.operand_a < fu_i.operand_b;
    assign equal         = fu_i.operand_a == fu_i.operand_b;

    // ----------------------------------------------------------------------
    // Result path
    // ----------------------------------------------------------------------
    always_comb begin
        // Adder is the default result
        result_o = fu_i.operand_a + fu_i.operand_b;
        case (fu_i.operator)
            ex_pkg::SUB:  result_o = fu_i.operand_a - fu_i.operand_b;
            ex_pkg::ANDL: result_o = fu_i.operand_a & fu_i.operand_b;
            ex_pkg::ORL:  result_o = fu_i.operand_a | fu_i.operand_b;
            ex_pkg::XORL: result_o = fu_i.operand_a ^ fu_i.operand_b;
            ex_pkg::SLL:  result_o = fu_i.operand_a << shamt;
            ex_pkg::SRL:  result_o = fu_i.operand_a >> shamt;
            ex_pkg::SRA:  result_o = ex_pkg::xlen_t'($signed(fu_i.operand_a) >>> shamt);
            ex_pkg::SLTS: result_o = ex_pkg::xlen_t'(less_signed);
            ex_pkg::SLTU: result_o = ex_pkg::xlen_t'(less_unsigned);
            default: ;
        endcase
    end

    // Branch condition, jumps are always taken
    always_comb begin
        case (fu_i.operator)
            ex_pkg::EQ:          branch_taken_o = equal;
            ex_pkg::NE:          branch_taken_o = !equal;
            ex_pkg::LTS:         branch_taken_o = less_signed;
            ex_pkg::GES:         branch_taken_o = !less_signed;
            ex_pkg::LTU:         branch_taken_o = less_unsigned;
            ex_pkg::GEU:         branch_taken_o = !less_unsigned;
            ex_pkg::JALR,
            ex_pkg::BRANCH_NONE: branch_taken_o = 1'b1;
            default:             branch_taken_o = 1'b0;
        endcase
    end

    // Issue logic must never route CSR, multiply or fence work here
    always_comb begin
        if (valid_i) begin
            assert final (fu_i.operator != ex_pkg::CSR_RW && fu_i.operator != ex_pkg::MUL
                          && fu_i.operator != ex_pkg::SFENCE_VMA)
                else $error("ALU issued with a non-ALU operator");
        end
    end

endmodule

// File: rtl/branch_unit.sv
// Branch target, link address and prediction resolution
`include "ex_consts.svh"

module branch_unit (
    fu_data_if.unit        fu_i,
    input  ex_pkg::xlen_t  pc_i,
    input  logic           is_compressed_i,
    input  logic           branch_valid_i,
    input  logic           other_valid_i,
    input  logic           branch_taken_i,
    input  logic           branch_predict_valid_i,
    input  ex_pkg::xlen_t  branch_predict_target_i,
    output ex_pkg::xlen_t  link_o,
    output logic           resolve_branch_o,
    output ex_pkg::xlen_t  resolved_target_o,
    output logic           is_mispredict_o
);

    ex_pkg::xlen_t target;
    ex_pkg::xlen_t next_pc;

    // jalr is register relative with bit 0 dropped, all others PC relative
    always_comb begin
        if (fu_i.operator == ex_pkg::JALR) begin
            target = (fu_i.operand_a + fu_i.imm) & ~ex_pkg::xlen_t'(1);
        end else begin
            target = pc_i + fu_i.imm;
        end
    end

    assign link_o  = pc_i + (is_compressed_i ? ex_pkg::xlen_t'(`EX_INSTR_BYTES_C)
                                             : ex_pkg::xlen_t'(`EX_INSTR_BYTES));
    assign next_pc = branch_taken_i ? target : link_o;

    // ----------------------------------------------------------------------
    // Resolution against the frontend prediction
    // ----------------------------------------------------------------------
    always_comb begin
        resolve_branch_o  = 1'b0;
        resolved_target_o = next_pc;
        is_mispredict_o   = 1'b0;
        if (branch_valid_i) begin
            resolve_branch_o = 1'b1;
            is_mispredict_o  = (branch_predict_valid_i != branch_taken_i)
                             || (branch_predict_valid_i && branch_predict_target_i != next_pc);
        end else if (other_valid_i && branch_predict_valid_i) begin
            // Predicted taken on something that is not a branch
            resolve_branch_o  = 1'b1;
            resolved_target_o = link_o;
            is_mispredict_o   = 1'b1;
        end
    end

endmodule

// File: rtl/csr_buffer.sv
// Single-entry CSR address buffer, held until commit
module csr_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    fu_data_if.unit           fu_i,
    input  logic              csr_valid_i,
    input  logic              csr_commit_i,
    output logic              csr_ready_o,
    output ex_pkg::xlen_t     csr_result_o,
    output ex_pkg::csr_addr_t csr_addr_o,
    output logic              csr_addr_valid_o
);

    ex_pkg::csr_state_e state_q;
    ex_pkg::csr_addr_t  addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ex_pkg::CSR_EMPTY;
        end else if (flush_i || csr_commit_i) begin
            state_q <= ex_pkg::CSR_EMPTY;
        end else if (csr_valid_i) begin
            state_q <= ex_pkg::CSR_FULL;
        end
    end

    // Address sits in the immediate field
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= ex_pkg::csr_addr_t'(fu_i.imm);
        end
    end

    assign csr_ready_o      = state_q == ex_pkg::CSR_EMPTY;
    assign csr_addr_valid_o = state_q == ex_pkg::CSR_FULL;
    assign csr_addr_o       = addr_q;
    // Write-back value is rs1, the CSR itself is read at commit
    assign csr_result_o     = fu_i.operand_a;

    // Issuer honours ready, commit only follows an issue
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> state_q == ex_pkg::CSR_EMPTY)
        else $error("CSR issued while buffer full");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_commit_i |-> state_q == ex_pkg::CSR_FULL)
        else $error("CSR commit while buffer empty");

endmodule

// File: rtl/ex_pkg.sv
// Shared word, ID, address and operator types of the execute stage
`include "ex_consts.svh"

package ex_pkg;

    // Widths with a meaning
    typedef logic [`EX_XLEN-1:0]          xlen_t;
    typedef logic [`EX_TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [`EX_ASID_BITS-1:0]     asid_t;

    // Operators decoded by all fixed-latency units
    typedef enum logic [`EX_OP_BITS-1:0] {
        ADD,
        SUB,
        ANDL,
        ORL,
        XORL,
        SLL,
        SRL,
        SRA,
        SLTS,
        SLTU,
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        JALR,
        BRANCH_NONE,
        CSR_RW,
        MUL,
        SFENCE_VMA
    } fu_op_e;

    // Single-entry CSR buffer occupancy
    typedef enum logic {
        CSR_EMPTY,
        CSR_FULL
    } csr_state_e;

endpackage

// File: rtl/ex_stage.sv
// Fixed-latency execute stage top with write-back multiplexer and issue ready
module ex_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  ex_pkg::fu_op_e    operator_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  ex_pkg::xlen_t     imm_i,
    input  ex_pkg::trans_id_t trans_id_i,
    input  ex_pkg::xlen_t     pc_i,
    input  logic              is_compressed_i,
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              csr_valid_i,
    input  logic              mult_valid_i,
    input  logic              csr_commit_i,
    input  logic              branch_predict_valid_i,
    input  ex_pkg::xlen_t     branch_predict_target_i,
    input  ex_pkg::xlen_t     rs1_forwarding_i,
    input  ex_pkg::xlen_t     rs2_forwarding_i,
    output ex_pkg::xlen_t     flu_result_o,
    output ex_pkg::trans_id_t flu_trans_id_o,
    output logic              flu_valid_o,
    output logic              flu_ready_o,
    output logic              resolve_branch_o,
    output ex_pkg::xlen_t     resolved_target_o,
    output logic              is_mispredict_o,
    output ex_pkg::csr_addr_t csr_addr_o,
    output logic              csr_addr_valid_o,
    output logic              sfence_pending_o,
    output ex_pkg::xlen_t     flush_vaddr_o,
    output ex_pkg::asid_t     flush_asid_o
);

    ex_pkg::xlen_t     alu_result;
    logic              alu_taken;
    ex_pkg::xlen_t     branch_link;
    ex_pkg::xlen_t     csr_result;
    ex_pkg::xlen_t     mult_result;
    ex_pkg::trans_id_t mult_trans_id;
    logic              mult_valid;

    // Shared issue port
    fu_data_if fu_bus ();

    assign fu_bus.operator  = operator_i;
    assign fu_bus.operand_a = operand_a_i;
    assign fu_bus.operand_b = operand_b_i;
    assign fu_bus.imm       = imm_i;
    assign fu_bus.trans_id  = trans_id_i;

    // ----------------------------------------------------------------------
    // Functional units
    // ----------------------------------------------------------------------
    alu i_alu (
        .fu_i           (fu_bus.unit),
        .valid_i        (alu_valid_i | branch_valid_i),
        .result_o       (alu_result),
        .branch_taken_o (alu_taken)
    );

    branch_unit i_branch_unit (
        .fu_i                    (fu_bus.unit),
        .pc_i                    (pc_i),
        .is_compressed_i         (is_compressed_i),
        .branch_valid_i          (branch_valid_i),
        .other_valid_i           (alu_valid_i | csr_valid_i | mult_valid_i),
        .branch_taken_i          (alu_taken),
        .branch_predict_valid_i  (branch_predict_valid_i),
        .branch_predict_target_i (branch_predict_target_i),
        .link_o                  (branch_link),
        .resolve_branch_o        (resolve_branch_o),
        .resolved_target_o       (resolved_target_o),
        .is_mispredict_o         (is_mispredict_o)
    );

    csr_buffer i_csr_buffer (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .fu_i             (fu_bus.unit),
        .csr_valid_i      (csr_valid_i),
        .csr_commit_i     (csr_commit_i),
        .csr_ready_o      (flu_ready_o),
        .csr_result_o     (csr_result),
        .csr_addr_o       (csr_addr_o),
        .csr_addr_valid_o (csr_addr_valid_o)
    );

    multiplier i_multiplier (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_i         (fu_bus.unit),
        .mult_valid_i (mult_valid_i),
        .mult_valid_o (mult_valid),
        .result_o     (mult_result),
        .trans_id_o   (mult_trans_id)
    );

    sfence_capture i_sfence_capture (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .fu_i             (fu_bus.unit),
        .csr_valid_i      (csr_valid_i),
        .rs1_i            (rs1_forwarding_i),
        .rs2_i            (rs2_forwarding_i),
        .sfence_pending_o (sfence_pending_o),
        .flush_vaddr_o    (flush_vaddr_o),
        .flush_asid_o     (flush_asid_o)
    );

    // ----------------------------------------------------------------------
    // Write-back port
    // ----------------------------------------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;

    // ALU first, then CSR, then multiplier, link address otherwise
    always_comb begin
        flu_result_o   = branch_link;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

    // Slot after a multiply belongs to its result
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |=> !(alu_valid_i || branch_valid_i || csr_valid_i))
        else $error("Issue collides with multiplier write-back");

endmodule

// File: rtl/fu_data_if.sv
// Issued operation bundle shared by the fixed-latency units
interface fu_data_if;

    ex_pkg::fu_op_e    operator;
    ex_pkg::xlen_t     operand_a;
    ex_pkg::xlen_t     operand_b;
    ex_pkg::xlen_t     imm;
    ex_pkg::trans_id_t trans_id;

    // Issue side drives the operation
    modport issuer (output operator, output operand_a, output operand_b,
                    output imm, output trans_id);

    // Functional units only observe it
    modport unit (input operator, input operand_a, input operand_b,
                  input imm, input trans_id);

endinterface

// File: rtl/multiplier.sv
// One-cycle multiplier, low product word with its transaction ID
module multiplier (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    fu_data_if.unit           fu_i,
    input  logic              mult_valid_i,
    output logic              mult_valid_o,
    output ex_pkg::xlen_t     result_o,
    output ex_pkg::trans_id_t trans_id_o
);

    ex_pkg::xlen_t     product;
    logic              valid_q;
    ex_pkg::xlen_t     result_q;
    ex_pkg::trans_id_t trans_id_q;

    // Only the low word is kept
    assign product = fu_i.operand_a * fu_i.operand_b;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= product;
            trans_id_q <= fu_i.trans_id;
        end
    end

    assign mult_valid_o = valid_q;
    assign result_o     = result_q;
    assign trans_id_o   = trans_id_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |-> fu_i.operator == ex_pkg::MUL)
        else $error("Multiplier issued with a non-multiply operator");

endmodule

// File: rtl/sfence_capture.sv
// Pending sfence.vma flag and its captured flush operands
module sfence_capture (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          flush_i,
    fu_data_if.unit       fu_i,
    input  logic          csr_valid_i,
    input  ex_pkg::xlen_t rs1_i,
    input  ex_pkg::xlen_t rs2_i,
    output logic          sfence_pending_o,
    output ex_pkg::xlen_t flush_vaddr_o,
    output ex_pkg::asid_t flush_asid_o
);

    logic          sfence_issue;
    logic          pending_q;
    ex_pkg::xlen_t vaddr_q;
    ex_pkg::asid_t asid_q;

    assign sfence_issue = csr_valid_i && fu_i.operator == ex_pkg::SFENCE_VMA;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (flush_i) begin
            pending_q <= 1'b0;
        end else if (sfence_issue) begin
            pending_q <= 1'b1;
        end
    end

    // Track the forwarded operands until a fence freezes them
    always_ff @(posedge clk_i) begin
        if (!pending_q && !sfence_issue) begin
            vaddr_q <= rs1_i;
            asid_q  <= ex_pkg::asid_t'(rs2_i);
        end
    end

    assign sfence_pending_o = pending_q;
    assign flush_vaddr_o    = vaddr_q;
    assign flush_asid_o     = asid_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module tb_ex_stage -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ex_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with exit status $status"
    exit "$status"
fi

echo "Simulation completed"
exit 0

// File: testbench/tb_ex_stage.sv
// Testbench for the execute stage with reference model, output checker and watchdog
module tb_ex_stage;

    // Reset, ALU, multiply, branch, CSR and sfence cycles with some slack
    localparam int unsigned PLANNED_CYCLES = 460;

    logic              clk_i;
    logic              rst_n;
    logic              flush;
    ex_pkg::fu_op_e    operator;
    ex_pkg::xlen_t     operand_a;
    ex_pkg::xlen_t     operand_b;
    ex_pkg::xlen_t     imm;
    ex_pkg::trans_id_t trans_id;
    ex_pkg::xlen_t     pc;
    logic              is_compressed;
    logic              alu_valid;
    logic              branch_valid;
    logic              csr_valid;
    logic              mult_valid;
    logic              csr_commit;
    logic              predict_valid;
    ex_pkg::xlen_t     predict_target;
    ex_pkg::xlen_t     rs1_fwd;
    ex_pkg::xlen_t     rs2_fwd;

    ex_pkg::xlen_t     flu_result_o;
    ex_pkg::trans_id_t flu_trans_id_o;
    logic              flu_valid_o;
    logic              flu_ready_o;
    logic              resolve_branch_o;
    ex_pkg::xlen_t     resolved_target_o;
    logic              is_mispredict_o;
    ex_pkg::csr_addr_t csr_addr_o;
    logic              csr_addr_valid_o;
    logic              sfence_pending_o;
    ex_pkg::xlen_t     flush_vaddr_o;
    ex_pkg::asid_t     flush_asid_o;

    // Expected state for the current cycle
    logic              checking;
    logic              exp_valid;
    ex_pkg::xlen_t     exp_result;
    ex_pkg::trans_id_t exp_tid;
    logic              exp_resolve;
    ex_pkg::xlen_t     exp_target;
    logic              exp_mispredict;
    logic              csr_full;
    ex_pkg::csr_addr_t exp_csr_addr;
    logic              exp_pending;
    logic              chk_fence;
    ex_pkg::xlen_t     exp_vaddr;
    ex_pkg::asid_t     exp_asid;

    ex_stage i_dut (
        .clk_i                   (clk_i),
        .rst_ni                  (rst_n),
        .flush_i                 (flush),
        .operator_i              (operator),
        .operand_a_i             (operand_a),
        .operand_b_i             (operand_b),
        .imm_i                   (imm),
        .trans_id_i              (trans_id),
        .pc_i                    (pc),
        .is_compressed_i         (is_compressed),
        .alu_valid_i             (alu_valid),
        .branch_valid_i          (branch_valid),
        .csr_valid_i             (csr_valid),
        .mult_valid_i            (mult_valid),
        .csr_commit_i            (csr_commit),
        .branch_predict_valid_i  (predict_valid),
        .branch_predict_target_i (predict_target),
        .rs1_forwarding_i        (rs1_fwd),
        .rs2_forwarding_i        (rs2_fwd),
        .flu_result_o            (flu_result_o),
        .flu_trans_id_o          (flu_trans_id_o),
        .flu_valid_o             (flu_valid_o),
        .flu_ready_o             (flu_ready_o),
        .resolve_branch_o        (resolve_branch_o),
        .resolved_target_o       (resolved_target_o),
        .is_mispredict_o         (is_mispredict_o),
        .csr_addr_o              (csr_addr_o),
        .csr_addr_valid_o        (csr_addr_valid_o),
        .sfence_pending_o        (sfence_pending_o),
        .flush_vaddr_o           (flush_vaddr_o),
        .flush_asid_o            (flush_asid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic ex_pkg::xlen_t ref_result(
        input  ex_pkg::fu_op_e op,
        input  ex_pkg::xlen_t  a,
        input  ex_pkg::xlen_t  b,
        input  ex_pkg::xlen_t  offs,
        input  ex_pkg::xlen_t  pc_v,
        input  logic           compressed,
        input  logic           is_branch,
        input  logic           pred,
        input  ex_pkg::xlen_t  pred_target,
        output logic           resolve,
        output ex_pkg::xlen_t  target,
        output logic           mispredict
    );
        ex_pkg::xlen_t res;
        ex_pkg::xlen_t link;
        ex_pkg::xlen_t dest;
        logic          taken;
        res   = '0;
        taken = 1'b0;
        link  = pc_v + (compressed ? 2 : 4);
        case (op)
            ex_pkg::ADD:    res = a + b;
            ex_pkg::SUB:    res = a - b;
            ex_pkg::ANDL:   res = a & b;
            ex_pkg::ORL:    res = a | b;
            ex_pkg::XORL:   res = a ^ b;
            ex_pkg::SLL:    res = a << b[4:0];
            ex_pkg::SRL:    res = a >> b[4:0];
            ex_pkg::SRA:    res = ex_pkg::xlen_t'($signed(a) >>> b[4:0]);
            ex_pkg::SLTS:   res = ex_pkg::xlen_t'($signed(a) < $signed(b));
            ex_pkg::SLTU:   res = ex_pkg::xlen_t'(a < b);
            ex_pkg::MUL:    res = a * b;
            ex_pkg::CSR_RW: res = a;
            ex_pkg::SFENCE_VMA: res = a;
            ex_pkg::EQ:     taken = a == b;
            ex_pkg::NE:     taken = a != b;
            ex_pkg::LTS:    taken = $signed(a) < $signed(b);
            ex_pkg::GES:    taken = $signed(a) >= $signed(b);
            ex_pkg::LTU:    taken = a < b;
            ex_pkg::GEU:    taken = a >= b;
            ex_pkg::JALR:   taken = 1'b1;
            ex_pkg::BRANCH_NONE: taken = 1'b1;
            default: ;
        endcase
        if (is_branch) begin
            res  = link;
            dest = (op == ex_pkg::JALR) ? ((a + offs) & 32'hffff_fffe) : pc_v + offs;
            if (!taken) begin
                dest = link;
            end
            resolve    = 1'b1;
            target     = dest;
            mispredict = pred ? (!taken || pred_target != dest) : taken;
        end else begin
            // A prediction on anything else falls through to the link
            resolve    = pred;
            target     = link;
            mispredict = pred;
        end
        return res;
    endfunction

    task automatic check_value(input string what, input ex_pkg::xlen_t got,
                               input ex_pkg::xlen_t want);
        assert (got == want) else begin
            $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, want);
            $display("FAIL: see errors above");
            $fatal(1, "Output check failed");
        end
    endtask

    // Advance one cycle with idle inputs and fresh forwarding values
    task automatic start_cycle();
        @(posedge clk_i);
        #2;
        alu_valid      = 1'b0;
        branch_valid   = 1'b0;
        csr_valid      = 1'b0;
        mult_valid     = 1'b0;
        csr_commit     = 1'b0;
        flush          = 1'b0;
        predict_valid  = 1'b0;
        rs1_fwd        = $urandom;
        rs2_fwd        = $urandom;
        exp_valid      = 1'b0;
        exp_resolve    = 1'b0;
        exp_mispredict = 1'b0;
    endtask

    // Unit 0 ALU, 1 branch, 2 CSR, 3 multiplier
    task automatic issue_op(input int unit, input ex_pkg::fu_op_e op, input logic pred,
                            output ex_pkg::xlen_t result);
        ex_pkg::xlen_t dest;
        logic          rsv;
        logic          misp;
        operator      = op;
        operand_a     = $urandom;
        operand_b     = ($urandom_range(0, 3) == 0) ? operand_a : $urandom;
        imm           = $urandom;
        trans_id      = ex_pkg::trans_id_t'($urandom);
        pc            = $urandom & 32'hffff_fffe;
        is_compressed = 1'($urandom_range(0, 1));
        result = ref_result(op, operand_a, operand_b, imm, pc, is_compressed, unit == 1,
                            1'b0, '0, rsv, dest, misp);
        // Half the predictions point at the real next PC
        predict_valid  = pred;
        predict_target = ($urandom_range(0, 1) == 1) ? dest : $urandom;
        result = ref_result(op, operand_a, operand_b, imm, pc, is_compressed, unit == 1,
                            pred, predict_target, exp_resolve, exp_target, exp_mispredict);
        case (unit)
            0: alu_valid = 1'b1;
            1: branch_valid = 1'b1;
            2: begin
                csr_valid    = 1'b1;
                exp_csr_addr = ex_pkg::csr_addr_t'(imm);
            end
            default: mult_valid = 1'b1;
        endcase
        if (unit != 3) begin
            exp_valid  = 1'b1;
            exp_result = result;
            exp_tid    = trans_id;
        end
    endtask

    // ----------------------------------------------------------------------
    // Checker on the falling edge where outputs are settled
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (checking) begin
            check_value("flu_valid_o", ex_pkg::xlen_t'(flu_valid_o), ex_pkg::xlen_t'(exp_valid));
            if (exp_valid) begin
                check_value("flu_result_o", flu_result_o, exp_result);
                check_value("flu_trans_id_o", ex_pkg::xlen_t'(flu_trans_id_o),
                            ex_pkg::xlen_t'(exp_tid));
            end
            check_value("resolve_branch_o", ex_pkg::xlen_t'(resolve_branch_o),
                        ex_pkg::xlen_t'(exp_resolve));
            check_value("is_mispredict_o", ex_pkg::xlen_t'(is_mispredict_o),
                        ex_pkg::xlen_t'(exp_mispredict));
            if (exp_resolve) begin
                check_value("resolved_target_o", resolved_target_o, exp_target);
            end
            check_value("flu_ready_o", ex_pkg::xlen_t'(flu_ready_o), ex_pkg::xlen_t'(!csr_full));
            check_value("csr_addr_valid_o", ex_pkg::xlen_t'(csr_addr_valid_o),
                        ex_pkg::xlen_t'(csr_full));
            if (csr_full) begin
                check_value("csr_addr_o", ex_pkg::xlen_t'(csr_addr_o),
                            ex_pkg::xlen_t'(exp_csr_addr));
            end
            check_value("sfence_pending_o", ex_pkg::xlen_t'(sfence_pending_o),
                        ex_pkg::xlen_t'(exp_pending));
            if (chk_fence) begin
                check_value("flush_vaddr_o", flush_vaddr_o, exp_vaddr);
                check_value("flush_asid_o", ex_pkg::xlen_t'(flush_asid_o),
                            ex_pkg::xlen_t'(exp_asid));
            end
        end
    end

    initial begin
        repeat (20 * PLANNED_CYCLES) @(posedge clk_i);
        $display("ERROR: watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $fatal(1, "Timeout");
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        ex_pkg::xlen_t     res;
        ex_pkg::xlen_t     prev_result;
        ex_pkg::trans_id_t prev_tid;
        void'($urandom(32'hcbf0));
        rst_n = 1'b0;
        flush = 1'b0;
        operator = ex_pkg::ADD;
        operand_a = '0;
        operand_b = '0;
        imm = '0;
        trans_id = '0;
        pc = '0;
        is_compressed = 1'b0;
        alu_valid = 1'b0;
        branch_valid = 1'b0;
        csr_valid = 1'b0;
        mult_valid = 1'b0;
        csr_commit = 1'b0;
        predict_valid = 1'b0;
        predict_target = '0;
        rs1_fwd = '0;
        rs2_fwd = '0;
        checking = 1'b0;
        exp_valid = 1'b0;
        exp_resolve = 1'b0;
        exp_mispredict = 1'b0;
        csr_full = 1'b0;
        exp_pending = 1'b0;
        chk_fence = 1'b0;
        repeat (4) @(posedge clk_i);
        #2;
        rst_n = 1'b1;
        checking = 1'b1;
        start_cycle();

        for (int i = 0; i < 200; i++) begin
            start_cycle();
            issue_op(0, ex_pkg::fu_op_e'($urandom_range(0, 9)), 1'b0, res);
        end

        // Back-to-back multiplies with each result one cycle later
        for (int i = 0; i < 100; i++) begin
            start_cycle();
            if (i > 0) begin
                exp_valid  = 1'b1;
                exp_result = prev_result;
                exp_tid    = prev_tid;
            end
            issue_op(3, ex_pkg::MUL, 1'($urandom_range(0, 1)), prev_result);
            prev_tid = trans_id;
        end
        start_cycle();
        exp_valid  = 1'b1;
        exp_result = prev_result;
        exp_tid    = prev_tid;

        // Branches and jumps, then ALU work under a live prediction
        for (int i = 0; i < 100; i++) begin
            start_cycle();
            issue_op(1, ex_pkg::fu_op_e'($urandom_range(10, 17)), 1'($urandom_range(0, 1)), res);
        end
        for (int i = 0; i < 20; i++) begin
            start_cycle();
            issue_op(0, ex_pkg::fu_op_e'($urandom_range(0, 9)), 1'b1, res);
        end

        // CSR held for a varying number of cycles before commit
        for (int n = 0; n < 4; n++) begin
            start_cycle();
            issue_op(2, ex_pkg::CSR_RW, 1'b0, res);
            start_cycle();
            csr_full = 1'b1;
            repeat (n) start_cycle();
            start_cycle();
            csr_commit = 1'b1;
            start_cycle();
            csr_full = 1'b0;
        end

        // sfence.vma keeps the operands of the cycle before its issue
        start_cycle();
        exp_vaddr = rs1_fwd;
        exp_asid  = ex_pkg::asid_t'(rs2_fwd);
        start_cycle();
        issue_op(2, ex_pkg::SFENCE_VMA, 1'b0, res);
        chk_fence = 1'b1;
        start_cycle();
        csr_full    = 1'b1;
        exp_pending = 1'b1;
        repeat (4) start_cycle();
        start_cycle();
        flush = 1'b1;
        start_cycle();
        csr_full    = 1'b0;
        exp_pending = 1'b0;
        chk_fence   = 1'b0;

        start_cycle();
        @(posedge clk_i);
        $display("PASS: all tests");
        $finish;
    end

endmodule
